// ==== project.f ====
logic/mesh_pkg.sv
logic/packet_fifo.sv
logic/mesh_endpoint.sv
logic/wb_request_fsm.sv
logic/credit_counter.sv
logic/endpoint_tile.sv
dv/tile_assertions.sv
dv/tile_tb.sv

// ==== Makefile ====
# Verilator build and run for the endpoint tile testbench

TOP = tile_tb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/tile_tb.sv ====
// testbench for the mesh endpoint tile
// models a mesh source and sink, a Wishbone slave memory and the local core
// expected returns come from expected_ret and a shadow copy of memory
`timescale 1ns/1ns

module tile_tb;

   import mesh_pkg::*;

   localparam int MEM_WORDS = 256;
   localparam int TIMEOUT   = 200;
   localparam logic [31:0] SEED = 32'h06e8_d177;

   logic              clk_i;
   logic              rst_n_i;
   logic              fwd_v_i;
   req_pkt_t          fwd_data_i;
   logic              fwd_ready_o;
   logic              out_fwd_v_o;
   req_pkt_t          out_fwd_data_o;
   logic              out_fwd_ready_i;
   logic              rev_v_o;
   ret_pkt_t          rev_data_o;
   logic              rev_ready_i;
   logic              rev_v_i;
   ret_pkt_t          rev_data_i;
   logic              rev_ready_o;
   logic              wb_cyc_o;
   logic              wb_stb_o;
   logic              wb_we_o;
   logic [ADDR_W-1:0] wb_adr_o;
   logic [DATA_W-1:0] wb_dat_o;
   logic [DATA_W-1:0] wb_dat_i;
   logic              wb_ack_i;
   logic              core_out_v_i;
   req_pkt_t          core_out_pkt_i;
   logic              core_out_ready_o;
   logic              core_ret_v_o;
   ret_pkt_t          core_ret_pkt_o;
   logic              core_ret_yumi_i;

   // memory model and its shadow
   logic [DATA_W-1:0] wb_mem [MEM_WORDS];
   logic [DATA_W-1:0] shadow [MEM_WORDS];
   // expected reverse link returns, expected core returns
   ret_pkt_t          exp_q [$];
   ret_pkt_t          core_q [$];
   logic [31:0]       rng;
   logic [31:0]       ack_rng;
   int                val_errs;
   int                timeouts;
   string             cur_test;
   bit                core_pop_en;

   endpoint_tile DUT (.*);

   // ------------------------------
   // clock
   // ------------------------------
   initial begin
      clk_i = 1'b0;
      forever begin
         #2 clk_i = ~clk_i;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // return packet as the tile should build it
   function automatic ret_pkt_t expected_ret(input req_pkt_t r,
                                             input logic [DATA_W-1:0] sh [MEM_WORDS]);
      ret_pkt_t p;
      p         = '0;
      p.op      = r.op;
      p.load_id = r.load_id;
      p.dst_x   = r.src_x;
      p.dst_y   = r.src_y;
      // loads read the word, stores carry zero
      p.data    = (r.op == OP_LOAD) ? sh[r.addr[7:0]] : '0;
      return p;
   endfunction

   // ------------------------------
   // run end and reporting
   // ------------------------------
   task automatic finish_run();
      $display("errors: %0d value, %0d timeout", val_errs, timeouts);
      if (val_errs == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   endtask

   task automatic fail_timeout(input string what);
      $display("timeout in %s: %s", cur_test, what);
      timeouts++;
      finish_run();
   endtask

   task automatic value_error(input logic [63:0] exp_v, input logic [63:0] act_v);
      $display("ERR %s: expected %h actual %h", cur_test, exp_v, act_v);
      val_errs++;
   endtask

   // ------------------------------
   // Wishbone slave memory
   // ------------------------------
   // random 0..3 cycle ack delay, ack dropped once taken
   initial begin
      int  wait_cnt;
      bit  busy;
      busy = 0;
      wait_cnt = 0;
      forever begin
         @(negedge clk_i);
         if (wb_cyc_o && wb_stb_o && !wb_ack_i) begin
            if (!busy) begin
               busy = 1;
               ack_rng = xorshift(ack_rng);
               wait_cnt = ack_rng % 4;
            end
            if (wait_cnt == 0) begin
               busy = 0;
               wb_ack_i = 1'b1;
               if (wb_adr_o >= MEM_WORDS) begin
                  $display("Wishbone address out of range in %s", cur_test);
                  val_errs++;
               end else if (wb_we_o) begin
                  wb_mem[wb_adr_o[7:0]] = wb_dat_o;
               end else begin
                  wb_dat_i = wb_mem[wb_adr_o[7:0]];
               end
            end else begin
               wait_cnt--;
            end
         end else begin
            wb_ack_i = 1'b0;
         end
      end
   end

   // ------------------------------
   // reverse link sink, compares
   // ------------------------------
   initial begin
      ret_pkt_t e;
      forever begin
         @(negedge clk_i);
         #1;
         if (rst_n_i && rev_v_o && rev_ready_i) begin
            if (exp_q.size() == 0) begin
               $display("unexpected return packet on reverse link in %s", cur_test);
               val_errs++;
            end else begin
               e = exp_q.pop_front();
               if (rev_data_o != e) begin
                  value_error(64'(e), 64'(rev_data_o));
               end
            end
         end
      end
   end

   // local core pops returned packets and checks them
   initial begin
      ret_pkt_t e;
      forever begin
         @(negedge clk_i);
         core_ret_yumi_i = 1'b0;
         if (core_ret_v_o && core_pop_en) begin
            if (core_q.size() == 0) begin
               $display("unexpected packet for the core in %s", cur_test);
               val_errs++;
            end else begin
               e = core_q.pop_front();
               if (core_ret_pkt_o != e) begin
                  value_error(64'(e), 64'(core_ret_pkt_o));
               end
            end
            core_ret_yumi_i = 1'b1;
         end
      end
   end

   // ------------------------------
   // mesh source and core tasks
   // ------------------------------
   function automatic req_pkt_t rand_req(input op_e op, input logic [7:0] addr,
                                         input int id);
      req_pkt_t p;
      rng       = xorshift(rng);
      p.op      = op;
      p.addr    = ADDR_W'(addr);
      p.data    = rng;
      p.src_x   = rng[3:0];
      p.src_y   = rng[7:4];
      p.load_id = ID_W'(id);
      return p;
   endfunction

   // gives up after limit cycles, the expectation goes in on transfer
   task automatic send_req(input req_pkt_t pkt, input int limit, output bit ok);
      int t;
      t  = 0;
      ok = 0;
      @(negedge clk_i);
      fwd_v_i    = 1'b1;
      fwd_data_i = pkt;
      #1;
      while (!fwd_ready_o && t < limit) begin
         @(negedge clk_i);
         #1;
         t++;
      end
      if (fwd_ready_o) begin
         ok = 1;
         exp_q.push_back(expected_ret(pkt, shadow));
         if (pkt.op == OP_STORE) begin
            shadow[pkt.addr[7:0]] = pkt.data;
         end
      end
      @(negedge clk_i);
      fwd_v_i = 1'b0;
   endtask

   task automatic send_core(input req_pkt_t pkt, input int limit, output bit ok);
      int t;
      t  = 0;
      ok = 0;
      @(negedge clk_i);
      core_out_v_i   = 1'b1;
      core_out_pkt_i = pkt;
      #1;
      while (!core_out_ready_o && t < limit) begin
         @(negedge clk_i);
         #1;
         t++;
      end
      ok = core_out_ready_o;
      // taken requests reach the mesh unchanged, refused ones not at all
      if (ok) begin
         if (!out_fwd_v_o) begin
            value_error(64'(1), 64'(out_fwd_v_o));
         end else if (out_fwd_data_o != pkt) begin
            value_error(64'(pkt), 64'(out_fwd_data_o));
         end
      end else if (out_fwd_v_o && out_fwd_ready_i) begin
         $display("outgoing request reached the mesh without a credit in %s", cur_test);
         val_errs++;
      end
      @(negedge clk_i);
      core_out_v_i = 1'b0;
   endtask

   task automatic inject_ret(input ret_pkt_t pkt);
      int t;
      t = 0;
      @(negedge clk_i);
      rev_v_i    = 1'b1;
      rev_data_i = pkt;
      #1;
      while (!rev_ready_o) begin
         @(negedge clk_i);
         #1;
         t++;
         if (t > TIMEOUT) begin
            fail_timeout("return fifo never took a packet");
         end
      end
      core_q.push_back(pkt);
      @(negedge clk_i);
      rev_v_i = 1'b0;
   endtask

   task automatic wait_drain();
      int t;
      t = 0;
      while (exp_q.size() != 0 || core_q.size() != 0) begin
         @(negedge clk_i);
         t++;
         if (t > TIMEOUT) begin
            fail_timeout("expected returns never arrived");
         end
      end
      // room for any stray extra return to show up
      repeat (10) @(negedge clk_i);
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      req_pkt_t    pkt;
      ret_pkt_t    rp;
      logic [7:0]  addrs [8];
      bit          ok;
      bit          dropped;
      int          n;
      val_errs = 0;
      timeouts = 0;
      rng      = SEED;
      ack_rng  = xorshift(~SEED);
      cur_test = "reset";
      core_pop_en = 1;
      rst_n_i = 1'b0;
      fwd_v_i = 1'b0;
      fwd_data_i = '0;
      out_fwd_ready_i = 1'b0;
      rev_ready_i = 1'b1;
      rev_v_i = 1'b0;
      rev_data_i = '0;
      wb_dat_i = '0;
      wb_ack_i = 1'b0;
      core_out_v_i = 1'b0;
      core_out_pkt_i = '0;
      core_ret_yumi_i = 1'b0;
      // fill depends on every address bit
      for (int i = 0; i < MEM_WORDS; i++) begin
         wb_mem[i] = {~i[7:0], i[7:0] ^ 8'h5a, i[7:0], 8'hc3 ^ i[7:0]};
         shadow[i] = wb_mem[i];
      end
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_n_i = 1'b1;
      #1;
      if (!fwd_ready_o || wb_cyc_o || wb_stb_o || rev_v_o || core_ret_v_o) begin
         $display("outputs not at their reset values after reset");
         val_errs++;
      end

      // stores then loads to the same addresses
      cur_test = "store_load";
      for (int i = 0; i < 8; i++) begin
         rng = xorshift(rng);
         addrs[i] = rng[7:0];
         send_req(rand_req(OP_STORE, addrs[i], i), TIMEOUT, ok);
         if (!ok) fail_timeout("request link never ready");
      end
      for (int i = 0; i < 8; i++) begin
         send_req(rand_req(OP_LOAD, addrs[i], 8 + i), TIMEOUT, ok);
         if (!ok) fail_timeout("request link never ready");
      end
      wait_drain();
      cur_test = "store_mem";
      for (int i = 0; i < 8; i++) begin
         if (wb_mem[addrs[i]] != shadow[addrs[i]]) begin
            value_error(64'(shadow[addrs[i]]), 64'(wb_mem[addrs[i]]));
         end
      end

      // reverse link stalled until the request link fills
      cur_test = "backpressure";
      rev_ready_i = 1'b0;
      dropped = 0;
      n = 0;
      while (!dropped && n < 12) begin
         rng = xorshift(rng);
         pkt = rand_req(rng[0] ? OP_STORE : OP_LOAD, rng[15:8], n);
         send_req(pkt, 20, ok);
         dropped = !ok;
         n++;
      end
      if (!dropped) begin
         $display("request link ready never dropped under back-pressure");
         val_errs++;
      end
      @(negedge clk_i);
      rev_ready_i = 1'b1;
      wait_drain();

      // credits, checked from core port transfers only
      cur_test = "credits";
      out_fwd_ready_i = 1'b1;
      for (int i = 0; i < MAX_CREDITS; i++) begin
         send_core(rand_req(OP_LOAD, 8'(i), i), 10, ok);
         if (!ok) begin
            $display("outgoing request %0d refused with credits left", i);
            val_errs++;
         end
      end
      for (int k = 0; k <= MAX_CREDITS; k++) begin
         send_core(rand_req(OP_LOAD, 8'(k), k), 6, ok);
         if (ok) begin
            $display("outgoing request accepted with no credit left");
            val_errs++;
         end
         if (k == MAX_CREDITS) break;
         rng = xorshift(rng);
         rp = ret_pkt_t'({rng, rng[13:0]});
         inject_ret(rp);
         send_core(rand_req(OP_LOAD, 8'(k), k), 10, ok);
         if (!ok) begin
            $display("returned packet did not reopen a credit");
            val_errs++;
         end
      end
      wait_drain();

      // returned packets pass to the core unchanged
      cur_test = "core_returns";
      core_pop_en = 0;
      for (int i = 0; i < 6; i++) begin
         // full return fifo refuses the link until the core pops
         if (i == RET_FIFO_ELS) begin
            #1;
            if (rev_ready_o) begin
               $display("return link still ready with the return fifo full");
               val_errs++;
            end
            core_pop_en = 1;
         end
         rng = xorshift(rng);
         rp = ret_pkt_t'({rng ^ 32'h1357_9bdf, rng[19:6]});
         inject_ret(rp);
      end
      wait_drain();

      finish_run();
   end

endmodule

// ==== dv/tile_assertions.sv ====
// concurrent checks on tile handshakes, bound to endpoint_tile
// Wishbone cycle end and stability, credit limit and reverse link hold
`timescale 1ns/1ns

module tile_assertions (
   input logic                          clk_i,
   input logic                          rst_n_i,
   input logic                          wb_cyc_o,
   input logic                          wb_stb_o,
   input logic                          wb_ack_i,
   input logic [mesh_pkg::ADDR_W-1:0]   wb_adr_o,
   input logic                          rev_v_o,
   input logic                          rev_ready_i,
   input logic                          out_fwd_v_o,
   input logic                          out_fwd_ready_i,
   input logic [mesh_pkg::CREDIT_W-1:0] credit_count
);

   import mesh_pkg::*;

   // cyc and stb both low the cycle after ack
   a_drop_after_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wb_cyc_o && wb_stb_o && wb_ack_i) |=> (!wb_cyc_o && !wb_stb_o))
      else $error("wishbone cycle still open after ack");

   // address held until ack
   a_adr_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (wb_stb_o && !wb_ack_i) |=> (wb_stb_o && $stable(wb_adr_o)))
      else $error("wishbone address or stb changed before ack");

   // no transfer onto the mesh once every credit is out
   a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (credit_count == CREDIT_W'(MAX_CREDITS)) |-> !(out_fwd_v_o && out_fwd_ready_i))
      else $error("outgoing request sent with no credit left");

   a_rev_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (rev_v_o && !rev_ready_i) |=> rev_v_o) else $error("rev valid dropped unaccepted");

endmodule

bind endpoint_tile tile_assertions u_tile_assertions (
   .clk_i           (clk_i),
   .rst_n_i         (rst_n_i),
   .wb_cyc_o        (wb_cyc_o),
   .wb_stb_o        (wb_stb_o),
   .wb_ack_i        (wb_ack_i),
   .wb_adr_o        (wb_adr_o),
   .rev_v_o         (rev_v_o),
   .rev_ready_i     (rev_ready_i),
   .out_fwd_v_o     (out_fwd_v_o),
   .out_fwd_ready_i (out_fwd_ready_i),
   .credit_count    (u_credit.count_r)
);

// ==== logic/endpoint_tile.sv ====
// top of the mesh endpoint tile
// mesh links, local Wishbone master and local core ports
// ties the link endpoint, the request FSM and the credit counter together
`timescale 1ns/1ns

module endpoint_tile (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // mesh forward link in
   input  logic                        fwd_v_i,
   input  mesh_pkg::req_pkt_t          fwd_data_i,
   output logic                        fwd_ready_o,
   // mesh forward link out
   output logic                        out_fwd_v_o,
   output mesh_pkg::req_pkt_t          out_fwd_data_o,
   input  logic                        out_fwd_ready_i,
   // mesh reverse link out
   output logic                        rev_v_o,
   output mesh_pkg::ret_pkt_t          rev_data_o,
   input  logic                        rev_ready_i,
   // mesh reverse link in
   input  logic                        rev_v_i,
   input  mesh_pkg::ret_pkt_t          rev_data_i,
   output logic                        rev_ready_o,
   // Wishbone classic master
   output logic                        wb_cyc_o,
   output logic                        wb_stb_o,
   output logic                        wb_we_o,
   output logic [mesh_pkg::ADDR_W-1:0] wb_adr_o,
   output logic [mesh_pkg::DATA_W-1:0] wb_dat_o,
   input  logic [mesh_pkg::DATA_W-1:0] wb_dat_i,
   input  logic                        wb_ack_i,
   // local core
   input  logic                        core_out_v_i,
   input  mesh_pkg::req_pkt_t          core_out_pkt_i,
   output logic                        core_out_ready_o,
   output logic                        core_ret_v_o,
   output mesh_pkg::ret_pkt_t          core_ret_pkt_o,
   input  logic                        core_ret_yumi_i
);

   import mesh_pkg::*;

   // endpoint to FSM
   logic     req_v;
   req_pkt_t req_pkt;
   logic     req_yumi;
   logic     ret_v;
   ret_pkt_t ret_pkt;
   logic     ret_ready;
   // outgoing request path and credits
   logic     ep_out_ready;
   logic     credit_avail;
   logic     out_ready_gated;
   logic     ret_accept;

   // ------------------------------
   // credit gating
   // ------------------------------
   // link ready only counts while a credit is free
   assign out_ready_gated  = ep_out_ready && credit_avail;
   assign core_out_ready_o = out_ready_gated;

   mesh_endpoint u_endpoint (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .fwd_v_i         (fwd_v_i),
      .fwd_data_i      (fwd_data_i),
      .fwd_ready_o     (fwd_ready_o),
      .rev_v_o         (rev_v_o),
      .rev_data_o      (rev_data_o),
      .rev_ready_i     (rev_ready_i),
      .rev_v_i         (rev_v_i),
      .rev_data_i      (rev_data_i),
      .rev_ready_o     (rev_ready_o),
      .out_fwd_v_o     (out_fwd_v_o),
      .out_fwd_data_o  (out_fwd_data_o),
      .out_fwd_ready_i (out_fwd_ready_i),
      .req_v_o         (req_v),
      .req_pkt_o       (req_pkt),
      .req_yumi_i      (req_yumi),
      .ret_v_i         (ret_v),
      .ret_pkt_i       (ret_pkt),
      .ret_ready_o     (ret_ready),
      // no valid onto the mesh without a credit
      .out_v_i         (core_out_v_i && credit_avail),
      .out_pkt_i       (core_out_pkt_i),
      .out_ready_o     (ep_out_ready),
      .core_ret_v_o    (core_ret_v_o),
      .core_ret_pkt_o  (core_ret_pkt_o),
      .core_ret_yumi_i (core_ret_yumi_i),
      .ret_accept_o    (ret_accept)
   );

   wb_request_fsm u_fsm (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_v_i     (req_v),
      .req_pkt_i   (req_pkt),
      .req_yumi_o  (req_yumi),
      .ret_v_o     (ret_v),
      .ret_pkt_o   (ret_pkt),
      .ret_ready_i (ret_ready),
      .wb_cyc_o    (wb_cyc_o),
      .wb_stb_o    (wb_stb_o),
      .wb_we_o     (wb_we_o),
      .wb_adr_o    (wb_adr_o),
      .wb_dat_o    (wb_dat_o),
      .wb_dat_i    (wb_dat_i),
      .wb_ack_i    (wb_ack_i)
   );

   // transfer of an outgoing request takes a credit
   credit_counter u_credit (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .send_i         (core_out_v_i && out_ready_gated),
      .return_i       (ret_accept),
      .credit_avail_o (credit_avail)
   );

endmodule

// ==== logic/credit_counter.sv ====
// counts outgoing requests still waiting for their return
// send_i adds one, return_i removes one, both together leave it alone
// credit_avail_o stays high while another request may go out
`timescale 1ns/1ns

module credit_counter (
   input  logic clk_i,
   input  logic rst_n_i,
   input  logic send_i,
   input  logic return_i,
   output logic credit_avail_o
);

   import mesh_pkg::*;

   // requests in flight
   logic [CREDIT_W-1:0] count_r;

   // ------------------------------
   // up/down count
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         count_r <= '0;
      end else if (send_i && !return_i) begin
         // saturate at the limit
         if (count_r != CREDIT_W'(MAX_CREDITS)) begin
            count_r <= count_r + 1'b1;
         end
      end else if (return_i && !send_i) begin
         // stray return does not wrap below zero
         if (count_r != '0) begin
            count_r <= count_r - 1'b1;
         end
      end
   end

   assign credit_avail_o = (count_r < CREDIT_W'(MAX_CREDITS));

endmodule

// ==== logic/wb_request_fsm.sv ====
// services buffered requests one at a time on the local Wishbone bus
// pops a request in IDLE, runs one classic cycle in BUS, then offers the
// return packet in RESPOND until the reverse link takes it
// pop to first return valid is ack latency plus two cycles
`timescale 1ns/1ns

module wb_request_fsm (
   input  logic                        clk_i,
   input  logic                        rst_n_i,
   // request fifo head
   input  logic                        req_v_i,
   input  mesh_pkg::req_pkt_t          req_pkt_i,
   output logic                        req_yumi_o,
   // return packet out
   output logic                        ret_v_o,
   output mesh_pkg::ret_pkt_t          ret_pkt_o,
   input  logic                        ret_ready_i,
   // Wishbone classic master
   output logic                        wb_cyc_o,
   output logic                        wb_stb_o,
   output logic                        wb_we_o,
   output logic [mesh_pkg::ADDR_W-1:0] wb_adr_o,
   output logic [mesh_pkg::DATA_W-1:0] wb_dat_o,
   input  logic [mesh_pkg::DATA_W-1:0] wb_dat_i,
   input  logic                        wb_ack_i
);

   import mesh_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      BUS,
      RESPOND
   } state_e;

   state_e            state_r;
   state_e            state_nxt;
   // request being serviced
   req_pkt_t          req_r;
   // read data, or zero for a store
   logic [DATA_W-1:0] rdata_r;

   // ------------------------------
   // state register
   // ------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_r <= IDLE;
      end else begin
         state_r <= state_nxt;
      end
   end

   always_comb begin
      state_nxt = state_r;
      case (state_r)
         IDLE: begin
            if (req_v_i) begin
               state_nxt = BUS;
            end
         end
         // hold the cycle open until the slave acks
         BUS: begin
            if (wb_ack_i) begin
               state_nxt = RESPOND;
            end
         end
         // hold the return until the link takes it
         RESPOND: begin
            if (ret_ready_i) begin
               state_nxt = IDLE;
            end
         end
         default: begin
            state_nxt = IDLE;
         end
      endcase
   end

   // pop only when free
   assign req_yumi_o = (state_r == IDLE) && req_v_i;

   // ------------------------------
   // payload capture
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (req_yumi_o) begin
         req_r <= req_pkt_i;
      end
      // store returns carry zero data
      if ((state_r == BUS) && wb_ack_i) begin
         rdata_r <= (req_r.op == OP_LOAD) ? wb_dat_i : '0;
      end
   end

   // ------------------------------
   // Wishbone side
   // ------------------------------
   // cyc and stb together, low again the cycle after ack
   assign wb_cyc_o = (state_r == BUS);
   assign wb_stb_o = (state_r == BUS);
   // address and data come from the latched request, stable for the cycle
   assign wb_we_o  = (req_r.op == OP_STORE);
   assign wb_adr_o = req_r.addr;
   assign wb_dat_o = req_r.data;

   // ------------------------------
   // return packet
   // ------------------------------
   assign ret_v_o = (state_r == RESPOND);

   always_comb begin
      ret_pkt_o         = '0;
      ret_pkt_o.op      = req_r.op;
      ret_pkt_o.data    = rdata_r;
      ret_pkt_o.load_id = req_r.load_id;
      // goes back to whoever sent it
      ret_pkt_o.dst_x   = req_r.src_x;
      ret_pkt_o.dst_y   = req_r.src_y;
   end

endmodule

// ==== logic/mesh_endpoint.sv ====
// link-facing side of the tile
// buffers incoming requests for the request FSM and returned packets for the core
// outgoing requests and outgoing returns go straight through to the links
// ret_accept_o pulses once per returned packet taken off the reverse link
`timescale 1ns/1ns

module mesh_endpoint (
   input  logic               clk_i,
   input  logic               rst_n_i,
   // incoming requests from the mesh
   input  logic               fwd_v_i,
   input  mesh_pkg::req_pkt_t fwd_data_i,
   output logic               fwd_ready_o,
   // outgoing returns to the mesh
   output logic               rev_v_o,
   output mesh_pkg::ret_pkt_t rev_data_o,
   input  logic               rev_ready_i,
   // incoming returns from the mesh
   input  logic               rev_v_i,
   input  mesh_pkg::ret_pkt_t rev_data_i,
   output logic               rev_ready_o,
   // outgoing requests to the mesh
   output logic               out_fwd_v_o,
   output mesh_pkg::req_pkt_t out_fwd_data_o,
   input  logic               out_fwd_ready_i,
   // request fifo head toward the FSM
   output logic               req_v_o,
   output mesh_pkg::req_pkt_t req_pkt_o,
   input  logic               req_yumi_i,
   // return packets built by the FSM
   input  logic               ret_v_i,
   input  mesh_pkg::ret_pkt_t ret_pkt_i,
   output logic               ret_ready_o,
   // outgoing requests from the core
   input  logic               out_v_i,
   input  mesh_pkg::req_pkt_t out_pkt_i,
   output logic               out_ready_o,
   // buffered returns toward the core
   output logic               core_ret_v_o,
   output mesh_pkg::ret_pkt_t core_ret_pkt_o,
   input  logic               core_ret_yumi_i,
   // credit event
   output logic               ret_accept_o
);

   import mesh_pkg::*;

   // ------------------------------
   // incoming requests
   // ------------------------------
   // local memory may be busy, so requests wait here
   packet_fifo #(
      .payload_t (req_pkt_t),
      .ELS       (REQ_FIFO_ELS)
   ) u_req_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (fwd_v_i),
      .data_i  (fwd_data_i),
      .ready_o (fwd_ready_o),
      .v_o     (req_v_o),
      .data_o  (req_pkt_o),
      .yumi_i  (req_yumi_i)
   );

   // ------------------------------
   // outgoing returns
   // ------------------------------
   assign rev_v_o     = ret_v_i;
   assign rev_data_o  = ret_pkt_i;
   assign ret_ready_o = rev_ready_i;

   // ------------------------------
   // outgoing requests
   // ------------------------------
   // credit gating is applied above this block
   assign out_fwd_v_o    = out_v_i;
   assign out_fwd_data_o = out_pkt_i;
   assign out_ready_o    = out_fwd_ready_i;

   // ------------------------------
   // incoming returns
   // ------------------------------
   // held until the core pops them
   packet_fifo #(
      .payload_t (ret_pkt_t),
      .ELS       (RET_FIFO_ELS)
   ) u_ret_fifo (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (rev_v_i),
      .data_i  (rev_data_i),
      .ready_o (rev_ready_o),
      .v_o     (core_ret_v_o),
      .data_o  (core_ret_pkt_o),
      .yumi_i  (core_ret_yumi_i)
   );

   // one credit back per accepted return
   assign ret_accept_o = rev_v_i && rev_ready_o;

endmodule

// ==== logic/packet_fifo.sv ====
// small synchronous fifo for packets of any packed type
// valid/ready on the write side, valid/yumi on the read side
// a full fifo accepts a new entry in the same cycle the head is popped
`timescale 1ns/1ns

module packet_fifo #(
   parameter type payload_t = logic,
   parameter int  ELS       = 2
) (
   input  logic     clk_i,
   input  logic     rst_n_i,
   // write side
   input  logic     v_i,
   input  payload_t data_i,
   output logic     ready_o,
   // read side
   output logic     v_o,
   output payload_t data_o,
   input  logic     yumi_i
);

   // one bit minimum so a single entry fifo still elaborates
   localparam int PTR_W = (ELS > 1) ? $clog2(ELS) : 1;

   payload_t         mem [ELS];
   logic [PTR_W-1:0] wr_ptr_r;
   logic [PTR_W-1:0] rd_ptr_r;
   logic             full_r;
   logic             empty;
   logic             enq;
   logic             deq;
   logic [PTR_W-1:0] wr_ptr_nxt;
   logic [PTR_W-1:0] rd_ptr_nxt;

   // wrap explicitly, depth need not be a power of two
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(ELS - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // ------------------------------
   // status and handshakes
   // ------------------------------
   assign empty   = (wr_ptr_r == rd_ptr_r) && !full_r;
   assign v_o     = !empty;
   // room now, or room made by this cycle's pop
   assign ready_o = !full_r || yumi_i;
   assign enq     = v_i && ready_o;
   assign deq     = yumi_i && !empty;

   assign wr_ptr_nxt = ptr_inc(wr_ptr_r);
   assign rd_ptr_nxt = ptr_inc(rd_ptr_r);

   // head entry straight from storage
   assign data_o = mem[rd_ptr_r];

   // ------------------------------
   // storage
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (enq) begin
         mem[wr_ptr_r] <= data_i;
      end
   end

   // pointers and full flag
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         full_r   <= 1'b0;
      end else begin
         if (enq) begin
            wr_ptr_r <= wr_ptr_nxt;
         end
         if (deq) begin
            rd_ptr_r <= rd_ptr_nxt;
         end
         // occupancy only moves when exactly one side acts
         if (enq && !deq) begin
            full_r <= (wr_ptr_nxt == rd_ptr_r);
         end else if (deq && !enq) begin
            full_r <= 1'b0;
         end
      end
   end

endmodule

// ==== logic/mesh_pkg.sv ====
// shared definitions for the mesh endpoint tile
// packet layouts, field widths, opcodes and buffer sizing
// modules import this inside their body and use scoped names on their ports

package mesh_pkg;

   // ------------------------------
   // field widths
   // ------------------------------
   // word address of a request
   localparam int ADDR_W  = 16;
   localparam int DATA_W  = 32;
   // load id echoed back in the return
   localparam int ID_W    = 5;
   // x and y tile coordinates
   localparam int COORD_W = 4;

   // ------------------------------
   // sizing
   // ------------------------------
   // incoming request buffer depth
   localparam int REQ_FIFO_ELS = 4;
   // returned packet buffer depth
   localparam int RET_FIFO_ELS = 2;
   // outgoing requests allowed in flight
   localparam int MAX_CREDITS  = 4;
   // must hold 0 .. MAX_CREDITS inclusive
   localparam int CREDIT_W     = $clog2(MAX_CREDITS + 1);

   // request opcode
   typedef enum logic [0:0] {
      OP_LOAD  = 1'b0,
      OP_STORE = 1'b1
   } op_e;

   // request packet, as carried on the forward link
   typedef struct packed {
      op_e                op;
      logic [ADDR_W-1:0]  addr;
      logic [DATA_W-1:0]  data;
      logic [COORD_W-1:0] src_x;
      logic [COORD_W-1:0] src_y;
      logic [ID_W-1:0]    load_id;
   } req_pkt_t;

   // return packet, sent back toward the requester
   // data is zero for a store
   typedef struct packed {
      op_e                op;
      logic [DATA_W-1:0]  data;
      logic [ID_W-1:0]    load_id;
      logic [COORD_W-1:0] dst_x;
      logic [COORD_W-1:0] dst_y;
   } ret_pkt_t;

endpackage
